//--- sources.f
+incdir+src
src/apb_delay_pkg.sv
src/apb_if.sv
src/delay_cfg_if.sv
src/apb_splitter.sv
src/delay_config_regs.sv
src/apb_delayer.sv
src/apb_sram_slave.sv
src/apb_delay_top.sv
test/apb_delay_checker.sv
test/apb_delay_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module apb_delay_tb -o apb_delay_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/apb_delay_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- test/apb_delay_tb.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module apb_delay_tb;
    localparam int   RESET_CYCLES = 10;
    localparam int   MAX_RATIO    = 7;
    localparam logic RD           = 1'b0;
    localparam logic WR           = 1'b1;

    typedef struct packed {
        logic               write;
        logic [`APB_AW-1:0] addr;
        logic [`APB_DW-1:0] data;
        logic [`APB_SW-1:0] strb;
    } stim_t;

    logic               clock;
    logic               reset;
    logic [`APB_AW-1:0] paddr;
    logic               psel;
    logic               penable;
    logic [2:0]         pprot;
    logic               pwrite;
    logic [`APB_DW-1:0] pwdata;
    logic [`APB_SW-1:0] pstrb;
    logic               pready;
    logic [`APB_DW-1:0] prdata;
    logic               pslverr;
    int                 checks;
    int                 errors;
    int                 cycle_count = 0;
    int                 cycle_limit;
    stim_t              stimulus[$];

    apb_delay_top dut_i (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    apb_delay_checker checker_i (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .checks  (checks),
        .errors  (errors)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: simulation still running after %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic add_entry(input logic write, input logic [`APB_AW-1:0] addr,
                             input logic [`APB_DW-1:0] data, input logic [`APB_SW-1:0] strb);
        stim_t entry;
        entry = '{write, addr, data, strb};
        stimulus.push_back(entry);
    endtask

    // Setup, access until pready, then one idle cycle.
    task automatic run_transfer(input stim_t s);
        @(posedge clock);
        #1;
        paddr   = s.addr;
        pwrite  = s.write;
        pwdata  = s.data;
        pstrb   = s.strb;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #1;
        penable = 1'b1;
        do begin
            @(negedge clock);
        end while (!pready);
        @(posedge clock);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pprot   = 3'b000;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        // Registers after reset, byte merges, bad offset.
        add_entry(RD, 32'h1000_0000, 32'h0, 4'h0);
        add_entry(RD, 32'h1000_0004, 32'h0, 4'h0);
        add_entry(RD, 32'h1000_0008, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_0004, 32'h0000_0C05, 4'b0010);
        add_entry(RD, 32'h1000_0004, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_0004, 32'h0000_0B0A, 4'b0011);
        add_entry(RD, 32'h1000_000C, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_000C, 32'hFFFF_FFFF, 4'hF);
        // Memory byte lanes seen through both regions.
        add_entry(WR, 32'hA000_0010, 32'h1122_3344, 4'hF);
        add_entry(WR, 32'hA000_0010, 32'hAABB_CCDD, 4'b0101);
        add_entry(RD, 32'hA000_0010, 32'h0, 4'h0);
        add_entry(WR, 32'hA000_0014, 32'h5566_7788, 4'hF);
        add_entry(WR, 32'hA000_0014, 32'h99AA_0000, 4'b1100);
        add_entry(RD, 32'hC000_0014, 32'h0, 4'h0);
        add_entry(RD, 32'hC000_0010, 32'h0, 4'h0);
        // Ratio 0, then 7.
        add_entry(WR, 32'h1000_0000, 32'h0000_0000, 4'b0001);
        add_entry(RD, 32'hA000_0010, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_0000, 32'h0000_FF07, 4'b0001);
        add_entry(RD, 32'hA000_0014, 32'h0, 4'h0);
        // Window A to D, then delay off.
        add_entry(RD, 32'hC000_0010, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_0004, 32'h0000_0D0A, 4'b0011);
        add_entry(RD, 32'hC000_0010, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_0000, 32'h0000_0002, 4'b0001);
        add_entry(RD, 32'hC000_0014, 32'h0, 4'h0);
        add_entry(WR, 32'h1000_0008, 32'h0000_0000, 4'b0001);
        add_entry(RD, 32'hA000_0010, 32'h0, 4'h0);
        add_entry(WR, 32'hB000_0018, 32'hCAFE_F00D, 4'hF);
        add_entry(RD, 32'hA000_0018, 32'h0, 4'h0);
        add_entry(RD, 32'h1000_0008, 32'h0, 4'h0);
        // Unmapped nibbles 0, 2 and 9.
        add_entry(WR, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF);
        add_entry(WR, 32'h2000_0000, 32'h0000_00FF, 4'hF);
        add_entry(WR, 32'h9000_0014, 32'h1234_5678, 4'hF);
        add_entry(RD, 32'h9000_0010, 32'h0, 4'h0);
        add_entry(RD, 32'h0000_0000, 32'h0, 4'h0);
        add_entry(RD, 32'hA000_0010, 32'h0, 4'h0);
        add_entry(RD, 32'hA000_0014, 32'h0, 4'h0);
        add_entry(RD, 32'h1000_0000, 32'h0, 4'h0);
        cycle_limit = RESET_CYCLES + stimulus.size() * (4 + MAX_RATIO) * 2;

        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        foreach (stimulus[i]) begin
            run_transfer(stimulus[i]);
        end
        @(posedge clock);
        $display("transfers: %0d, checked: %0d, errors: %0d", stimulus.size(), checks, errors);
        if (errors == 0 && checks == stimulus.size()) begin
            $display("TEST PASSED");
        end else begin
            if (checks != stimulus.size()) begin
                $display("Checker saw %0d completed transfers, driver issued %0d",
                         checks, stimulus.size());
            end
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/apb_delay_checker.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module apb_delay_checker (
    input  logic               clock,
    input  logic               reset,
    input  logic [`APB_AW-1:0] paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_DW-1:0] pwdata,
    input  logic [`APB_SW-1:0] pstrb,
    input  logic               pready,
    input  logic [`APB_DW-1:0] prdata,
    input  logic               pslverr,
    output int                 checks,
    output int                 errors
);
    logic [`APB_DW-1:0]  mem_model [`MEM_WORDS];
    logic [`RATIO_W-1:0] ratio;
    logic [3:0]          window_lo;
    logic [3:0]          window_hi;
    logic                delay_enable;
    int                  cycles;

    function automatic int expected_latency(input logic [3:0] region);
        if (region == `CFG_REGION || region < `MEM_REGION_LO) begin
            return 1;
        end
        if (delay_enable && region >= window_lo && region < window_hi) begin
            // Latency w + 2 + w * ratio with one SRAM wait.
            return 3 + int'(ratio);
        end
        return 2;
    endfunction

    function automatic logic [`APB_DW-1:0] register_value(input logic [1:0] offset);
        case (offset)
            2'd0:    return {{(`APB_DW-`RATIO_W){1'b0}}, ratio};
            2'd1:    return {20'h0, window_hi, 4'h0, window_lo};
            2'd2:    return {31'h0, delay_enable};
            default: return '0;
        endcase
    endfunction

    task automatic apply_write(input logic [3:0] region, input logic [7:0] word);
        if (region == `CFG_REGION) begin
            case (paddr[3:2])
                2'd0: if (pstrb[0]) ratio = pwdata[`RATIO_W-1:0];
                2'd1: begin
                    if (pstrb[0]) window_lo = pwdata[3:0];
                    if (pstrb[1]) window_hi = pwdata[11:8];
                end
                2'd2: if (pstrb[0]) delay_enable = pwdata[0];
                default: ;
            endcase
        end else begin
            for (int lane = 0; lane < `APB_SW; lane++) begin
                if (pstrb[lane]) mem_model[word][lane*8 +: 8] = pwdata[lane*8 +: 8];
            end
        end
    endtask

    // Sample in mid-cycle where DUT outputs have settled.
    always @(negedge clock) begin
        logic [3:0]         region;
        logic [7:0]         word;
        logic [`APB_DW-1:0] exp_data;
        logic               exp_err;
        logic               unmapped;
        if (reset) begin
            ratio        = `RATIO_RESET;
            window_lo    = `WINDOW_LO_RESET;
            window_hi    = `WINDOW_HI_RESET;
            delay_enable = `ENABLE_RESET;
            cycles       = 0;
            checks       = 0;
            errors       = 0;
        end else if (psel && penable) begin
            cycles++;
            if (pready) begin
                region   = paddr[`APB_AW-1 -: 4];
                word     = paddr[9:2];
                unmapped = (region != `CFG_REGION) && (region < `MEM_REGION_LO);
                if (region == `CFG_REGION) begin
                    exp_err  = (paddr[3:2] == 2'd3);
                    exp_data = register_value(paddr[3:2]);
                end else begin
                    exp_err  = unmapped || int'(word) >= `MEM_WORDS;
                    exp_data = exp_err ? '0 : mem_model[word];
                end
                checks++;
                if (cycles != expected_latency(region)) begin
                    errors++;
                    $display("error %0t: 0x%08h ready in access cycle %0d, expected %0d",
                             $time, paddr, cycles, expected_latency(region));
                end
                if (pslverr !== exp_err) begin
                    errors++;
                    $display("error %0t: 0x%08h pslverr %b, expected %b",
                             $time, paddr, pslverr, exp_err);
                end
                if ((!pwrite || unmapped) && prdata !== exp_data) begin
                    errors++;
                    $display("error %0t: 0x%08h prdata 0x%08h, expected 0x%08h",
                             $time, paddr, prdata, exp_data);
                end
                if (pwrite && !exp_err) begin
                    apply_write(region, word);
                end
                cycles = 0;
            end
        end else begin
            cycles = 0;
        end
    end

endmodule

//--- src/apb_delay_top.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module apb_delay_top (
    input  logic               clock,
    input  logic               reset,
    input  logic [`APB_AW-1:0] paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic [2:0]         pprot,
    input  logic               pwrite,
    input  logic [`APB_DW-1:0] pwdata,
    input  logic [`APB_SW-1:0] pstrb,
    output logic               pready,
    output logic [`APB_DW-1:0] prdata,
    output logic               pslverr
);
    apb_if       host_bus ();
    apb_if       cfg_bus ();
    apb_if       mem_bus ();
    apb_if       slow_bus ();
    delay_cfg_if delay_cfg ();

    assign host_bus.paddr   = paddr;
    assign host_bus.psel    = psel;
    assign host_bus.penable = penable;
    assign host_bus.pprot   = pprot;
    assign host_bus.pwrite  = pwrite;
    assign host_bus.pwdata  = pwdata;
    assign host_bus.pstrb   = pstrb;
    assign pready           = host_bus.pready;
    assign prdata           = host_bus.prdata;
    assign pslverr          = host_bus.pslverr;

    apb_splitter splitter_i (
        .host (host_bus),
        .cfg  (cfg_bus),
        .mem  (mem_bus)
    );

    delay_config_regs regs_i (
        .clock (clock),
        .reset (reset),
        .bus   (cfg_bus),
        .cfg   (delay_cfg)
    );

    apb_delayer delayer_i (
        .clock      (clock),
        .reset      (reset),
        .upstream   (mem_bus),
        .downstream (slow_bus),
        .cfg        (delay_cfg)
    );

    apb_sram_slave sram_i (
        .clock (clock),
        .reset (reset),
        .bus   (slow_bus)
    );

endmodule

//--- src/apb_sram_slave.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module apb_sram_slave (
    input logic      clock,
    input logic      reset,
    apb_if.completer bus
);
    logic [`APB_DW-1:0] mem [`MEM_WORDS];
    logic [7:0]         word_idx;
    logic               in_range;
    logic               access;
    logic               waited;
    logic               done;

    assign word_idx = bus.paddr[9:2];
    assign in_range = (word_idx < `MEM_WORDS);
    assign access   = bus.psel & bus.penable;
    assign done     = access & waited;

    // One wait state per access phase.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            waited <= 1'b0;
        end else if (access) begin
            waited <= ~waited;
        end else begin
            waited <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (done && bus.pwrite && in_range) begin
            for (int lane = 0; lane < `APB_SW; lane++) begin
                if (bus.pstrb[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= bus.pwdata[lane*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        if (done && !bus.pwrite && in_range) begin
            bus.prdata = mem[word_idx];
        end else begin
            bus.prdata = '0;
        end
    end

    assign bus.pready  = done;
    assign bus.pslverr = done & ~in_range;

endmodule

//--- src/apb_delayer.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module apb_delayer (
    input logic        clock,
    input logic        reset,
    apb_if.completer   upstream,
    apb_if.requester   downstream,
    delay_cfg_if.sink  cfg
);
    import apb_delay_pkg::*;

    delay_state_t        state;
    logic [`COUNT_W-1:0] count;
    logic [`COUNT_W-1:0] ratio_ext;
    logic [`APB_DW-1:0]  rdata_q;
    logic                slverr_q;
    logic [3:0]          region;
    logic                in_window;
    logic                setup;
    logic                release_now;

    // Request side is untouched.
    assign downstream.paddr   = upstream.paddr;
    assign downstream.psel    = upstream.psel;
    assign downstream.penable = upstream.penable;
    assign downstream.pprot   = upstream.pprot;
    assign downstream.pwrite  = upstream.pwrite;
    assign downstream.pwdata  = upstream.pwdata;
    assign downstream.pstrb   = upstream.pstrb;

    assign region    = upstream.paddr[`APB_AW-1 -: 4];
    assign in_window = cfg.delay_enable &&
                       (region >= cfg.window_lo) && (region < cfg.window_hi);
    assign setup     = upstream.psel & ~upstream.penable;
    assign ratio_ext = {{(`COUNT_W-`RATIO_W){1'b0}}, cfg.ratio};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= DELAY_IDLE;
        end else begin
            case (state)
                DELAY_IDLE:    if (setup && in_window) state <= DELAY_REQUEST;
                DELAY_REQUEST: if (downstream.pready) state <= DELAY_HOLD;
                DELAY_HOLD:    if (count == '0) state <= DELAY_IDLE;
                default:       state <= DELAY_IDLE;
            endcase
        end
    end

    // Grows by ratio per completer wait cycle, then drains in hold.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case (state)
                DELAY_REQUEST: if (!downstream.pready) count <= count + ratio_ext;
                DELAY_HOLD:    if (count != '0) count <= count - 1'b1;
                default:       count <= '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == DELAY_REQUEST && downstream.pready) begin
            rdata_q  <= downstream.prdata;
            slverr_q <= downstream.pslverr;
        end
    end

    assign release_now = (state == DELAY_HOLD) && (count == '0);

    always_comb begin
        if (state == DELAY_IDLE) begin
            upstream.pready  = downstream.pready;
            upstream.prdata  = downstream.prdata;
            upstream.pslverr = downstream.pslverr;
        end else if (release_now) begin
            upstream.pready  = 1'b1;
            upstream.prdata  = rdata_q;
            upstream.pslverr = slverr_q;
        end else begin
            // Still stretching.
            upstream.pready  = 1'b0;
            upstream.prdata  = '0;
            upstream.pslverr = 1'b0;
        end
    end

endmodule

//--- src/delay_config_regs.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module delay_config_regs (
    input logic          clock,
    input logic          reset,
    apb_if.completer     bus,
    delay_cfg_if.source  cfg
);
    import apb_delay_pkg::*;

    logic [`RATIO_W-1:0] ratio;
    logic [3:0]          window_lo;
    logic [3:0]          window_hi;
    logic                delay_enable;
    cfg_reg_t            offset;
    logic                access;
    logic                bad_offset;

    assign offset     = cfg_reg_t'(bus.paddr[3:2]);
    assign access     = bus.psel & bus.penable;
    assign bad_offset = (bus.paddr[3:2] == 2'd3);

    // Window packs low bound in byte 0 and high bound in byte 1.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ratio        <= `RATIO_RESET;
            window_lo    <= `WINDOW_LO_RESET;
            window_hi    <= `WINDOW_HI_RESET;
            delay_enable <= `ENABLE_RESET;
        end else if (access && bus.pwrite) begin
            case (offset)
                CFG_RATIO: if (bus.pstrb[0]) ratio <= bus.pwdata[`RATIO_W-1:0];
                CFG_WINDOW: begin
                    if (bus.pstrb[0]) window_lo <= bus.pwdata[3:0];
                    if (bus.pstrb[1]) window_hi <= bus.pwdata[11:8];
                end
                CFG_ENABLE: if (bus.pstrb[0]) delay_enable <= bus.pwdata[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        bus.prdata = '0;
        case (offset)
            CFG_RATIO:  bus.prdata[`RATIO_W-1:0] = ratio;
            CFG_WINDOW: bus.prdata[11:0] = {window_hi, 4'h0, window_lo};
            CFG_ENABLE: bus.prdata[0] = delay_enable;
            default:    bus.prdata = '0;
        endcase
    end

    assign bus.pready  = access;
    assign bus.pslverr = access & bad_offset;

    assign cfg.ratio        = ratio;
    assign cfg.window_lo    = window_lo;
    assign cfg.window_hi    = window_hi;
    assign cfg.delay_enable = delay_enable;

endmodule

//--- src/apb_splitter.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

module apb_splitter (
    apb_if.completer host,
    apb_if.requester cfg,
    apb_if.requester mem
);
    logic [3:0] region;
    logic       sel_cfg;
    logic       sel_mem;

    assign region  = host.paddr[`APB_AW-1 -: 4];
    assign sel_cfg = (region == `CFG_REGION);
    assign sel_mem = (region >= `MEM_REGION_LO);

    // Register block branch.
    assign cfg.paddr   = host.paddr;
    assign cfg.psel    = host.psel & sel_cfg;
    assign cfg.penable = host.penable;
    assign cfg.pprot   = host.pprot;
    assign cfg.pwrite  = host.pwrite;
    assign cfg.pwdata  = host.pwdata;
    assign cfg.pstrb   = host.pstrb;

    // Memory branch.
    assign mem.paddr   = host.paddr;
    assign mem.psel    = host.psel & sel_mem;
    assign mem.penable = host.penable;
    assign mem.pprot   = host.pprot;
    assign mem.pwrite  = host.pwrite;
    assign mem.pwdata  = host.pwdata;
    assign mem.pstrb   = host.pstrb;

    always_comb begin
        if (sel_cfg) begin
            host.pready  = cfg.pready;
            host.prdata  = cfg.prdata;
            host.pslverr = cfg.pslverr;
        end else if (sel_mem) begin
            host.pready  = mem.pready;
            host.prdata  = mem.prdata;
            host.pslverr = mem.pslverr;
        end else begin
            // Unmapped address gets an immediate error.
            host.pready  = 1'b1;
            host.prdata  = '0;
            host.pslverr = 1'b1;
        end
    end

endmodule

//--- src/delay_cfg_if.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

interface delay_cfg_if;
    logic [`RATIO_W-1:0] ratio;
    logic [3:0]          window_lo;
    logic [3:0]          window_hi;
    logic                delay_enable;

    modport source (output ratio, window_lo, window_hi, delay_enable);
    modport sink   (input  ratio, window_lo, window_hi, delay_enable);
endinterface

//--- src/apb_if.sv
`timescale 1ns/1ps

`include "apb_delay_macros.svh"

interface apb_if;
    logic [`APB_AW-1:0] paddr;
    logic               psel;
    logic               penable;
    logic [2:0]         pprot;
    logic               pwrite;
    logic [`APB_DW-1:0] pwdata;
    logic [`APB_SW-1:0] pstrb;
    logic               pready;
    logic [`APB_DW-1:0] prdata;
    logic               pslverr;

    modport requester (
        output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );
endinterface

//--- src/apb_delay_pkg.sv
package apb_delay_pkg;

    // Delayer FSM states.
    typedef enum logic [1:0] {
        DELAY_IDLE    = 2'd0,
        DELAY_REQUEST = 2'd1,
        DELAY_HOLD    = 2'd2
    } delay_state_t;

    // Word offsets inside the register block.
    typedef enum logic [1:0] {
        CFG_RATIO  = 2'd0,
        CFG_WINDOW = 2'd1,
        CFG_ENABLE = 2'd2
    } cfg_reg_t;

endpackage

//--- src/apb_delay_macros.svh
`ifndef APB_DELAY_MACROS_SVH
`define APB_DELAY_MACROS_SVH

// Bus widths.
`define APB_AW 32
`define APB_DW 32
`define APB_SW 4

// Address regions by the top nibble of paddr.
`define CFG_REGION    4'h1
`define MEM_REGION_LO 4'hA

`define MEM_WORDS 256

// Delay settings and their reset values.
`define RATIO_W         8
`define COUNT_W         16
`define RATIO_RESET     8'd3
`define WINDOW_LO_RESET 4'hA
`define WINDOW_HI_RESET 4'hB
`define ENABLE_RESET    1'b1

`endif
